/* host_io.f */
rtl/host_io_pkg.sv
rtl/host_cmd_loader.sv
rtl/host_cmd_fifo.sv
rtl/host_regs.sv
rtl/host_io_top.sv
dv/host_io_tb.sv

/* dv/host_io_tb.sv */
// Testbench for host I/O top with reference model, queue-based checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module host_io_tb
  import host_io_pkg::*;
();

  localparam int      NUM_OPS    = 60;
  localparam longint  TIMEOUT_NS = (NUM_OPS * 40 + 200) * 100;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  op_valid_i;
  logic                  op_ready_o;
  loader_op_e            op_i;
  logic [ADDR_W-1:0]     op_addr_i;
  logic [DATA_W-1:0]     op_data_i;
  logic                  done_o;
  logic                  rsp_valid_o;
  mem_op_e               rsp_op_o;
  logic [TRACE_BITS-1:0] trace_en_o;
  logic                  finish_o;
  logic                  char_valid_o;
  logic [7:0]            char_o;
  logic                  char_ready_i;
  logic                  rd_valid_o;
  logic [DATA_W-1:0]     rd_data_o;

  logic [DATA_W-1:0]     exp_rd_q[$];
  logic [7:0]            exp_char_q[$];
  mem_op_e               exp_op_q[$];
  logic [TRACE_BITS-1:0] trace_sh;
  logic                  finish_sh;
  logic [31:0]           data_rng;
  logic [31:0]           ready_rng;
  logic                  char_ready_nxt;
  int                    char_mode;
  int                    err_cnt;
  int                    fail_cnt;
  int                    mem_cnt;
  int                    rsp_cnt;
  logic                  char_held;
  logic [7:0]            held_char;

  host_io_top DUT (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected read data from the shadow of earlier writes
  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] d;
    d = '0;
    if (addr == TRACE_EN_ADDR)
      d[TRACE_BITS-1:0] = trace_sh;
    else if (addr == FINISH_ADDR)
      d[0] = finish_sh;
    return d;
  endfunction

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_char(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input mem_op_e got, input mem_op_e exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic issue_op(input loader_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    logic ready;
    begin
      if (op == LOAD_READ)
        exp_rd_q.push_back(ref_read(addr));
      if (op == LOAD_WRITE && addr == TRACE_EN_ADDR)
        trace_sh = data[TRACE_BITS-1:0];
      if (op == LOAD_WRITE && addr == FINISH_ADDR)
        finish_sh = 1'b1;
      if (op == LOAD_WRITE && addr == PUTCHAR_ADDR)
        exp_char_q.push_back(data[7:0]);
      if (op == LOAD_WRITE)
        exp_op_q.push_back(MEM_WR);
      if (op == LOAD_READ)
        exp_op_q.push_back(MEM_RD);
      if (op == LOAD_WRITE || op == LOAD_READ)
        mem_cnt++;
      op_valid_i = 1'b1;
      op_i       = op;
      op_addr_i  = addr;
      op_data_i  = data;
      ready      = 1'b0;
      while (!ready)
      begin
        @(negedge clk_i);
        ready = op_ready_o;
        @(posedge clk_i);
      end
      #1;
      op_valid_i = 1'b0;
    end
  endtask

  task automatic fence_and_wait();
    issue_op(LOAD_FENCE, '0, '0);
    @(negedge clk_i);
    while (!op_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic hold_low(input int cycles, input logic watch_done);
    repeat (cycles)
    begin
      @(negedge clk_i);
      check_flag(op_ready_o, 1'b0, "op_ready_o while draining");
      if (watch_done)
        check_flag(done_o, 1'b0, "done_o while draining");
    end
  endtask

  function automatic logic [ADDR_W-1:0] unmapped_addr(input logic [31:0] r);
    logic [ADDR_W-1:0] a;
    a = r[ADDR_W-1:0];
    if (a == TRACE_EN_ADDR || a == FINISH_ADDR || a == PUTCHAR_ADDR)
      a = a ^ ADDR_W'('h4);
    return a;
  endfunction

  // Consumer side of the putchar port, mode sampled on the edge
  always @(posedge clk_i)
  begin
    ready_rng = lcg_next(ready_rng);
    case (char_mode)
      0:       char_ready_nxt = (ready_rng[31:24] >= 8'd77);
      1:       char_ready_nxt = 1'b0;
      default: char_ready_nxt = 1'b1;
    endcase
    #1;
    char_ready_i = char_ready_nxt;
  end

  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (rsp_valid_o)
      begin
        rsp_cnt++;
        if (exp_op_q.size() == 0)
        begin
          fail_cnt++;
          $display("Response at %0d ns with no command outstanding", $time);
        end
        else
          check_op(rsp_op_o, exp_op_q.pop_front(), "rsp_op_o");
      end
      if (rd_valid_o)
      begin
        if (exp_rd_q.size() == 0)
        begin
          fail_cnt++;
          $display("Read response at %0d ns with no read outstanding", $time);
        end
        else
          check_data(rd_data_o, exp_rd_q.pop_front(), "rd_data_o");
      end
      if (char_held)
      begin
        check_flag(char_valid_o, 1'b1, "char_valid_o held");
        check_char(char_o, held_char, "char_o held");
      end
      if (char_valid_o && char_ready_i)
      begin
        if (exp_char_q.size() == 0)
        begin
          fail_cnt++;
          $display("Character 0x%02h at %0d ns was never written", char_o, $time);
        end
        else
          check_char(char_o, exp_char_q.pop_front(), "char_o");
      end
      char_held = char_valid_o && !char_ready_i;
      held_char = char_o;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns with the DUT still busy", TIMEOUT_NS);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    op_valid_i   = 1'b0;
    op_i         = LOAD_WRITE;
    op_addr_i    = '0;
    op_data_i    = '0;
    char_ready_i = 1'b0;
    char_mode    = 2;
    data_rng     = 32'h4155_832f;
    ready_rng    = ~32'h4155_832f;
    trace_sh     = '0;
    finish_sh    = 1'b0;
    err_cnt      = 0;
    fail_cnt     = 0;
    mem_cnt      = 0;
    rsp_cnt      = 0;
    char_held    = 1'b0;
    held_char    = '0;
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // Reset values
    @(negedge clk_i);
    check_flag(op_ready_o, 1'b0, "op_ready_o first cycle");
    check_data(DATA_W'(trace_en_o), '0, "trace_en_o after reset");
    check_flag(finish_o, 1'b0, "finish_o after reset");
    check_flag(done_o, 1'b0, "done_o after reset");
    check_flag(char_valid_o, 1'b0, "char_valid_o after reset");
    @(posedge clk_i);
    #1;
    issue_op(LOAD_READ, TRACE_EN_ADDR, '0);

    // Trace-enable writes and read-backs
    char_mode = 0;
    repeat (8)
    begin
      data_rng = lcg_next(data_rng);
      issue_op(LOAD_WRITE, TRACE_EN_ADDR, data_rng);
      issue_op(LOAD_READ, TRACE_EN_ADDR, '0);
    end
    fence_and_wait();
    check_data(DATA_W'(trace_en_o), DATA_W'(trace_sh), "trace_en_o");

    // Putchar burst with random back-pressure
    repeat (20)
    begin
      data_rng = lcg_next(data_rng);
      issue_op(LOAD_WRITE, PUTCHAR_ADDR, data_rng);
    end
    fence_and_wait();
    check_data(exp_char_q.size(), 0, "characters missing after burst");

    // Unmapped addresses
    repeat (4)
    begin
      data_rng = lcg_next(data_rng);
      issue_op(LOAD_WRITE, unmapped_addr(data_rng), ~data_rng);
      data_rng = lcg_next(data_rng);
      issue_op(LOAD_READ, unmapped_addr(data_rng), '0);
    end
    fence_and_wait();
    check_data(DATA_W'(trace_en_o), DATA_W'(trace_sh), "trace_en_o after unmapped writes");
    check_flag(finish_o, 1'b0, "finish_o after unmapped writes");

    // Fence holds while characters are stuck
    char_mode = 1;
    repeat (5)
    begin
      data_rng = lcg_next(data_rng);
      issue_op(LOAD_WRITE, PUTCHAR_ADDR, data_rng);
    end
    issue_op(LOAD_FENCE, '0, '0);
    hold_low(10, 1'b0);
    char_mode = 0;
    @(negedge clk_i);
    while (!op_ready_o)
      @(negedge clk_i);
    check_data(exp_char_q.size(), 0, "characters pending when fence released");
    @(posedge clk_i);
    #1;

    // Finish register, then LOAD_FINISH
    issue_op(LOAD_WRITE, FINISH_ADDR, 32'h1);
    issue_op(LOAD_READ, FINISH_ADDR, '0);
    fence_and_wait();
    check_flag(finish_o, 1'b1, "finish_o");
    char_mode = 1;
    repeat (2)
    begin
      data_rng = lcg_next(data_rng);
      issue_op(LOAD_WRITE, PUTCHAR_ADDR, data_rng);
    end
    issue_op(LOAD_FINISH, '0, '0);
    hold_low(10, 1'b1);
    char_mode = 0;
    @(negedge clk_i);
    while (!done_o)
      @(negedge clk_i);
    check_data(rsp_cnt, mem_cnt, "responses when done_o rose");
    repeat (5)
    begin
      @(negedge clk_i);
      check_flag(op_ready_o, 1'b0, "op_ready_o after finish");
      check_flag(done_o, 1'b1, "done_o after finish");
    end

    if (exp_rd_q.size() != 0 || exp_char_q.size() != 0 || exp_op_q.size() != 0)
    begin
      fail_cnt++;
      $display("Expected responses, reads or characters never arrived");
    end
    $display("Checks done with %0d value errors and %0d other errors", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/host_io_top.sv */
// Host I/O top with loader, command buffer and host register block
`timescale 1ns/1ps
`default_nettype none

module host_io_top
  import host_io_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  op_valid_i,
  output logic                  op_ready_o,
  input  loader_op_e            op_i,
  input  logic [ADDR_W-1:0]     op_addr_i,
  input  logic [DATA_W-1:0]     op_data_i,
  output logic                  done_o,
  output logic                  rsp_valid_o,
  output mem_op_e               rsp_op_o,
  output logic [TRACE_BITS-1:0] trace_en_o,
  output logic                  finish_o,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  input  logic                  char_ready_i,
  output logic                  rd_valid_o,
  output logic [DATA_W-1:0]     rd_data_o
);

  logic              cmd_valid;
  logic              cmd_ready;
  mem_op_e           cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_data;
  logic              deq_valid;
  logic              deq_ready;
  mem_op_e           deq_op;
  logic [ADDR_W-1:0] deq_addr;
  logic [DATA_W-1:0] deq_data;
  logic              rsp_valid;
  mem_op_e           rsp_op;
  logic [DATA_W-1:0] rsp_data;

  assign rsp_valid_o = rsp_valid;
  assign rsp_op_o    = rsp_op;
  assign rd_valid_o  = rsp_valid & (rsp_op == MEM_RD);
  assign rd_data_o   = rsp_data;

  host_cmd_loader u_loader (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .op_valid_i  (op_valid_i),
    .op_ready_o  (op_ready_o),
    .op_i        (op_i),
    .op_addr_i   (op_addr_i),
    .op_data_i   (op_data_i),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .cmd_op_o    (cmd_op),
    .cmd_addr_o  (cmd_addr),
    .cmd_data_o  (cmd_data),
    .rsp_valid_i (rsp_valid),
    .done_o      (done_o)
  );

  host_cmd_fifo u_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_data_i  (cmd_data),
    .deq_valid_o (deq_valid),
    .deq_ready_i (deq_ready),
    .deq_op_o    (deq_op),
    .deq_addr_o  (deq_addr),
    .deq_data_o  (deq_data)
  );

  host_regs u_regs (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .deq_valid_i  (deq_valid),
    .deq_ready_o  (deq_ready),
    .deq_op_i     (deq_op),
    .deq_addr_i   (deq_addr),
    .deq_data_i   (deq_data),
    .rsp_valid_o  (rsp_valid),
    .rsp_op_o     (rsp_op),
    .rsp_data_o   (rsp_data),
    .trace_en_o   (trace_en_o),
    .finish_o     (finish_o),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .char_ready_i (char_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/host_regs.sv */
// Host register block with trace enables, finish flag, putchar port and responses
`timescale 1ns/1ps
`default_nettype none

module host_regs
  import host_io_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  deq_valid_i,
  output logic                  deq_ready_o,
  input  mem_op_e               deq_op_i,
  input  logic [ADDR_W-1:0]     deq_addr_i,
  input  logic [DATA_W-1:0]     deq_data_i,
  output logic                  rsp_valid_o,
  output mem_op_e               rsp_op_o,
  output logic [DATA_W-1:0]     rsp_data_o,
  output logic [TRACE_BITS-1:0] trace_en_o,
  output logic                  finish_o,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  input  logic                  char_ready_i
);

  logic [TRACE_BITS-1:0] trace_q;
  logic                  finish_q;
  logic                  char_valid_q;
  logic [7:0]            char_q;
  logic                  rsp_valid_q;
  mem_op_e               rsp_op_q;
  logic [DATA_W-1:0]     rsp_data_q;
  logic [DATA_W-1:0]     rd_data;
  logic                  is_putchar;
  logic                  is_write;
  logic                  accept;
  logic                  char_fire;

  assign is_write   = (deq_op_i == MEM_WR);
  assign is_putchar = is_write & (deq_addr_i == PUTCHAR_ADDR);
  assign char_fire  = char_valid_q & char_ready_i;

  // A pending character only lets another putchar through,
  // so its late response never meets a second one
  assign deq_ready_o = ~char_valid_q | (char_ready_i & is_putchar);
  assign accept      = deq_valid_i & deq_ready_o;

  assign trace_en_o   = trace_q;
  assign finish_o     = finish_q;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_op_o     = rsp_op_q;
  assign rsp_data_o   = rsp_data_q;

  // Read decode, unmapped reads return zero
  always_comb
  begin
    rd_data = '0;
    case (deq_addr_i)
      TRACE_EN_ADDR: rd_data[TRACE_BITS-1:0] = trace_q;
      FINISH_ADDR:   rd_data[0] = finish_q;
      default:       rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      trace_q      <= '0;
      finish_q     <= 1'b0;
      char_valid_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
    end
    else
    begin
      // Putchar answers after its handshake, the rest right away
      rsp_valid_q <= char_fire | (accept & ~is_putchar);

      if (char_fire)
        char_valid_q <= 1'b0;
      if (accept && is_putchar)
        char_valid_q <= 1'b1;

      if (accept && is_write)
      begin
        case (deq_addr_i)
          TRACE_EN_ADDR: trace_q <= deq_data_i[TRACE_BITS-1:0];
          FINISH_ADDR:   finish_q <= 1'b1;
          default:       trace_q <= trace_q;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept && is_putchar)
      char_q <= deq_data_i[7:0];

    if (char_fire)
    begin
      rsp_op_q   <= MEM_WR;
      rsp_data_q <= '0;
    end
    else if (accept)
    begin
      rsp_op_q   <= deq_op_i;
      rsp_data_q <= is_write ? '0 : rd_data;
    end
  end

  // Character held until the consumer takes it
  a_char_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (char_valid_o && !char_ready_i) |=> (char_valid_o && $stable(char_o)));

endmodule

`default_nettype wire

/* rtl/host_cmd_fifo.sv */
// Four-entry circular command buffer with valid/ready on push and pop sides
`timescale 1ns/1ps
`default_nettype none

module host_cmd_fifo
  import host_io_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,
  input  mem_op_e           cmd_op_i,
  input  logic [ADDR_W-1:0] cmd_addr_i,
  input  logic [DATA_W-1:0] cmd_data_i,
  output logic              deq_valid_o,
  input  logic              deq_ready_i,
  output mem_op_e           deq_op_o,
  output logic [ADDR_W-1:0] deq_addr_o,
  output logic [DATA_W-1:0] deq_data_o
);

  mem_op_e                          op_mem_q   [FIFO_DEPTH];
  logic [ADDR_W-1:0]                addr_mem_q [FIFO_DEPTH];
  logic [DATA_W-1:0]                data_mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]    rd_ptr_q;
  logic [$clog2(FIFO_DEPTH+1)-1:0]  count_q;
  logic                             push;
  logic                             pop;

  assign cmd_ready_o = (count_q != FIFO_DEPTH);
  assign deq_valid_o = (count_q != '0);
  assign push        = cmd_valid_i & cmd_ready_o;
  assign pop         = deq_valid_o & deq_ready_i;

  assign deq_op_o   = op_mem_q[rd_ptr_q];
  assign deq_addr_o = addr_mem_q[rd_ptr_q];
  assign deq_data_o = data_mem_q[rd_ptr_q];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      op_mem_q[wr_ptr_q]   <= cmd_op_i;
      addr_mem_q[wr_ptr_q] <= cmd_addr_i;
      data_mem_q[wr_ptr_q] <= cmd_data_i;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Occupancy matches the pointer distance, so no entry is overwritten or lost
  a_no_entry_lost: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (count_q <= FIFO_DEPTH) &&
    (wr_ptr_q == rd_ptr_q + count_q[$clog2(FIFO_DEPTH)-1:0]));

endmodule

`default_nettype wire

/* rtl/host_cmd_loader.sv */
// Loader FSM turning loader operations into commands, with outstanding-response counter
`timescale 1ns/1ps
`default_nettype none

module host_cmd_loader
  import host_io_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              op_valid_i,
  output logic              op_ready_o,
  input  loader_op_e        op_i,
  input  logic [ADDR_W-1:0] op_addr_i,
  input  logic [DATA_W-1:0] op_data_i,
  output logic              cmd_valid_o,
  input  logic              cmd_ready_i,
  output mem_op_e           cmd_op_o,
  output logic [ADDR_W-1:0] cmd_addr_o,
  output logic [DATA_W-1:0] cmd_data_o,
  input  logic              rsp_valid_i,
  output logic              done_o
);

  loader_state_e      state_q;
  logic               live_q;
  logic               fin_pend_q;
  logic               cmd_valid_q;
  mem_op_e            cmd_op_q;
  logic [ADDR_W-1:0]  cmd_addr_q;
  logic [DATA_W-1:0]  cmd_data_q;
  logic [OUTST_W-1:0] outst_q;
  logic               op_fire;
  logic               cmd_fire;
  logic               is_mem_op;
  logic               drained;

  assign cmd_fire  = cmd_valid_q & cmd_ready_i;
  assign is_mem_op = (op_i == LOAD_WRITE) | (op_i == LOAD_READ);
  assign drained   = (outst_q == '0) & ~cmd_valid_q;

  // Slot may refill in the cycle it drains
  assign op_ready_o = live_q & (state_q == ST_RUN) & (~cmd_valid_q | cmd_ready_i);
  assign op_fire    = op_valid_i & op_ready_o;

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_op_o    = cmd_op_q;
  assign cmd_addr_o  = cmd_addr_q;
  assign cmd_data_o  = cmd_data_q;
  assign done_o      = (state_q == ST_DONE);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q    <= ST_RUN;
      fin_pend_q <= 1'b0;
      live_q     <= 1'b0;
    end
    else
    begin
      live_q <= 1'b1;
      case (state_q)
        ST_RUN:
        begin
          // Fence and finish both wait for every response
          if (op_fire && !is_mem_op)
          begin
            state_q    <= ST_FENCE;
            fin_pend_q <= (op_i == LOAD_FINISH);
          end
        end
        ST_FENCE:
        begin
          if (drained)
            state_q <= fin_pend_q ? ST_DONE : ST_RUN;
        end
        ST_DONE: state_q <= ST_DONE;
        default: state_q <= ST_RUN;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cmd_valid_q <= 1'b0;
    else if (op_fire && is_mem_op)
      cmd_valid_q <= 1'b1;
    else if (cmd_fire)
      cmd_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (op_fire && is_mem_op)
    begin
      cmd_op_q   <= (op_i == LOAD_READ) ? MEM_RD : MEM_WR;
      cmd_addr_q <= op_addr_i;
      cmd_data_q <= op_data_i;
    end
  end

  // Counts from buffer acceptance to response
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      outst_q <= '0;
    else
      case ({cmd_fire, rsp_valid_i})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;
      endcase
  end

  // Every response matches a command already handed to the buffer
  a_outst_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i |-> (outst_q != '0));

  a_outst_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    outst_q <= OUTST_W'(FIFO_DEPTH + 2));

endmodule

`default_nettype wire

/* rtl/host_io_pkg.sv */
// Widths, host address map and enums for loader, command buffer and host registers
`default_nettype none

package host_io_pkg;

  // Command path widths
  localparam int ADDR_W = 20;
  localparam int DATA_W = 32;

  // One enable per tracer or profiler, bit 0 upward:
  // icache, dcache, lce, cce, dram, vm, cmt,
  // core profile, pc profile, branch profile, cosim
  localparam int TRACE_BITS = 11;

  localparam int FIFO_DEPTH = 4;

  // Buffer entries plus loader slot and register stage
  localparam int OUTST_W = 3;

  // Host register map
  localparam logic [ADDR_W-1:0] TRACE_EN_ADDR = 'h00100;
  localparam logic [ADDR_W-1:0] FINISH_ADDR   = 'h00200;
  localparam logic [ADDR_W-1:0] PUTCHAR_ADDR  = 'h01000;

  // Operations arriving at the loader
  typedef enum logic [1:0]
  {
    LOAD_WRITE  = 2'd0,
    LOAD_READ   = 2'd1,
    LOAD_FENCE  = 2'd2,
    LOAD_FINISH = 2'd3
  } loader_op_e;

  // Opcode carried by a memory-mapped command
  typedef enum logic
  {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  // Loader FSM states
  typedef enum logic [1:0]
  {
    ST_RUN   = 2'd0,
    ST_FENCE = 2'd1,
    ST_DONE  = 2'd2
  } loader_state_e;

endpackage

`default_nettype wire
